// ==== verilog/dcache_cfg_pkg.sv ====
// ==========================================================================
// cache geometry constants, address slices and tag entry type
// ==========================================================================

package dcache_cfg_pkg;

  // geometry
  localparam int WAY_NUM        = 2;
  localparam int SET_NUM        = 16;
  localparam int WORDS_PER_LINE = 4;

  // address split: tag | index | line offset
  localparam int ADDR_W = 32;
  localparam int IDX_W  = 4;
  localparam int OFS_W  = 4;
  localparam int TAG_W  = ADDR_W - IDX_W - OFS_W;

  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [IDX_W-1:0]             idx_t;
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [31:0]                  word_t;
  // word 0 sits in the low bits of the line
  typedef logic [WORDS_PER_LINE*32-1:0] line_t;
  typedef logic [$clog2(WAY_NUM)-1:0]   way_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

// ==== verilog/dcache_bus_pkg.sv ====
// ==========================================================================
// cpu request/response structs and the AXI4 channel payloads
// ==========================================================================

package dcache_bus_pkg;

  // beats per line transfer, fixed incrementing 4-byte bursts
  localparam int BURST_LEN = 4;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } mem_op_t;

  typedef enum logic [1:0] {
    SZ_B,
    SZ_H,
    SZ_W
  } acc_size_t;

  typedef struct packed {
    mem_op_t               op;
    acc_size_t             size;
    logic                  is_unsigned;
    dcache_cfg_pkg::addr_t addr;
    dcache_cfg_pkg::word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    mem_op_t               op;
    dcache_cfg_pkg::word_t rdata;
  } cpu_rsp_t;

  // shared by AW and AR
  typedef struct packed {
    dcache_cfg_pkg::addr_t addr;
    logic [7:0]            len;
  } axi_addr_t;

  // shared by W and R
  typedef struct packed {
    dcache_cfg_pkg::word_t data;
    logic                  last;
  } axi_wdata_t;

endpackage

// ==== verilog/dcache_ram.sv ====
// ==========================================================================
// one write port array with a registered write-first read port
// ==========================================================================
`timescale 1ns/1ps

module dcache_ram #(
  parameter int DEPTH = dcache_cfg_pkg::SET_NUM,
  parameter int WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  we_i,
  input  dcache_cfg_pkg::idx_t  waddr_i,
  input  logic [WIDTH-1:0]      wdata_i,
  input  dcache_cfg_pkg::idx_t  raddr_i,
  output logic [WIDTH-1:0]      rdata_o
);

  logic [WIDTH-1:0] mem_q [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else begin
      if (we_i) begin
        mem_q[waddr_i] <= wdata_i;
      end
      // same-entry write bypasses to the read port
      if (we_i && (waddr_i == raddr_i)) begin
        rdata_o <= wdata_i;
      end else begin
        rdata_o <= mem_q[raddr_i];
      end
    end
  end

endmodule

// ==== verilog/dcache_lookup.sv ====
// ==========================================================================
// tag arrays, tag compare, per-set pseudo-LRU and victim selection
// ==========================================================================
`timescale 1ns/1ps

module dcache_lookup (
  input  logic                       clk,
  input  logic                       rst_n,
  input  dcache_cfg_pkg::idx_t       ridx_i,
  // high when the stage 1 request moves on
  input  logic                       s1_valid_i,
  input  dcache_cfg_pkg::addr_t      s1_addr_i,
  input  logic                       tag_we_i,
  input  dcache_cfg_pkg::way_t       tag_way_i,
  input  dcache_cfg_pkg::idx_t       tag_idx_i,
  input  dcache_cfg_pkg::tag_entry_t tag_entry_i,
  output logic                       hit_o,
  output dcache_cfg_pkg::way_t       hit_way_o,
  output dcache_cfg_pkg::way_t       victim_way_o,
  output dcache_cfg_pkg::tag_entry_t victim_entry_o
);
  import dcache_cfg_pkg::*;

  tag_entry_t         entry [WAY_NUM];
  logic [WAY_NUM-1:0] match;
  logic [SET_NUM-1:0] plru_q;
  idx_t               s1_idx;
  tag_t               s1_tag;

  assign s1_idx = s1_addr_i[OFS_W +: IDX_W];
  assign s1_tag = s1_addr_i[ADDR_W-1 -: TAG_W];

  for (genvar w = 0; w < WAY_NUM; w++) begin : g_tag_ram
    dcache_ram #(
      .DEPTH (SET_NUM),
      .WIDTH ($bits(tag_entry_t))
    ) u_tag_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (tag_we_i && (tag_way_i == way_t'(w))),
      .waddr_i (tag_idx_i),
      .wdata_i (tag_entry_i),
      .raddr_i (ridx_i),
      .rdata_o (entry[w])
    );

    assign match[w] = entry[w].valid && (entry[w].tag == s1_tag);
  end

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (match[w]) begin
        hit_way_o = way_t'(w);
      end
    end
  end

  assign hit_o = |match;

  // plru bit names the way to replace next
  assign victim_way_o   = hit_o ? hit_way_o : plru_q[s1_idx];
  assign victim_entry_o = entry[victim_way_o];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      plru_q <= '0;
    end else if (s1_valid_i) begin
      // point away from the way just used
      plru_q[s1_idx] <= ~victim_way_o;
    end
  end

endmodule

// ==== verilog/dcache_align_unit.sv ====
// ==========================================================================
// load data extraction with extension, store byte merge into a line
// ==========================================================================
`timescale 1ns/1ps

module dcache_align_unit (
  input  dcache_cfg_pkg::line_t     line_i,
  input  dcache_cfg_pkg::addr_t     addr_i,
  input  dcache_bus_pkg::acc_size_t size_i,
  input  logic                      is_unsigned_i,
  input  dcache_cfg_pkg::word_t     wdata_i,
  output dcache_cfg_pkg::word_t     rdata_o,
  output dcache_cfg_pkg::line_t     merged_o
);
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  logic [OFS_W-1:0] ofs;
  word_t            word_sel;
  logic [7:0]       byte_sel;
  logic [15:0]      half_sel;

  assign ofs      = addr_i[OFS_W-1:0];
  assign word_sel = line_i[ofs[OFS_W-1:2]*32 +: 32];
  assign byte_sel = word_sel[ofs[1:0]*8 +: 8];
  assign half_sel = word_sel[ofs[1]*16 +: 16];

  // load path
  always_comb begin
    case (size_i)
      SZ_B:    rdata_o = {{24{byte_sel[7] & ~is_unsigned_i}}, byte_sel};
      SZ_H:    rdata_o = {{16{half_sel[15] & ~is_unsigned_i}}, half_sel};
      SZ_W:    rdata_o = word_sel;
      default: rdata_o = word_sel;
    endcase
  end

  // store path, aligned accesses only
  always_comb begin
    merged_o = line_i;
    case (size_i)
      SZ_B:    merged_o[ofs*8 +: 8]  = wdata_i[7:0];
      SZ_H:    merged_o[ofs*8 +: 16] = wdata_i[15:0];
      default: merged_o[ofs*8 +: 32] = wdata_i;
    endcase
  end

endmodule

// ==== verilog/dcache_miss_fsm.sv ====
// ==========================================================================
// miss FSM: dirty victim write-back burst, refill burst and refill buffer
// ==========================================================================
`timescale 1ns/1ps

module dcache_miss_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start_i,
  input  logic                       dirty_i,
  input  dcache_cfg_pkg::addr_t      victim_addr_i,
  input  dcache_cfg_pkg::addr_t      fill_addr_i,
  input  dcache_cfg_pkg::line_t      victim_line_i,
  output logic                       idle_o,
  output logic                       done_o,
  output dcache_cfg_pkg::line_t      fill_line_o,
  // write-back channels
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,
  output dcache_bus_pkg::axi_addr_t  aw_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,
  output dcache_bus_pkg::axi_wdata_t w_o,
  input  logic                       b_valid_i,
  output logic                       b_ready_o,
  // refill channels
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output dcache_bus_pkg::axi_addr_t  ar_o,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  input  dcache_bus_pkg::axi_wdata_t r_i
);
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WB_ADDR,
    WB_DATA,
    WB_RESP,
    RF_ADDR,
    RF_DATA
  } fill_state_t;

  fill_state_t                  state_q;
  fill_state_t                  state_d;
  logic [$clog2(BURST_LEN)-1:0] beat_q;
  logic                         beat_last;
  logic                         w_fire;
  logic                         r_fire;
  line_t                        fill_q;

  assign w_fire    = w_valid_o & w_ready_i;
  assign r_fire    = r_valid_i & r_ready_o;
  assign beat_last = (int'(beat_q) == BURST_LEN - 1);

  // ========================================================================
  // state transitions
  // ========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = dirty_i ? WB_ADDR : RF_ADDR;
      WB_ADDR: if (aw_ready_i) state_d = WB_DATA;
      WB_DATA: if (w_fire && beat_last) state_d = WB_RESP;
      WB_RESP: if (b_valid_i) state_d = RF_ADDR;
      RF_ADDR: if (ar_ready_i) state_d = RF_DATA;
      RF_DATA: if (r_fire && beat_last) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
      done_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_o  <= r_fire && beat_last;
      // counter restarts on every state change
      if (state_q != state_d) begin
        beat_q <= '0;
      end else if (w_fire || r_fire) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // refill words land in order
  always_ff @(posedge clk) begin
    if (r_fire) begin
      fill_q[beat_q*$bits(word_t) +: $bits(word_t)] <= r_i.data;
    end
  end

  // ========================================================================
  // AXI outputs
  // ========================================================================
  assign idle_o      = (state_q == IDLE);
  assign fill_line_o = fill_q;

  assign aw_valid_o = (state_q == WB_ADDR);
  assign aw_o.addr  = victim_addr_i;
  assign aw_o.len   = 8'(BURST_LEN - 1);

  assign w_valid_o = (state_q == WB_DATA);
  assign w_o.data  = victim_line_i[beat_q*$bits(word_t) +: $bits(word_t)];
  assign w_o.last  = beat_last;
  assign b_ready_o = 1'b1;

  assign ar_valid_o = (state_q == RF_ADDR);
  assign ar_o.addr  = fill_addr_i;
  assign ar_o.len   = 8'(BURST_LEN - 1);
  assign r_ready_o  = (state_q == RF_DATA);

endmodule

// ==== verilog/dcache_top.sv ====
// ==========================================================================
// data cache top: stage registers, data arrays, stall control, instances
// ==========================================================================
`timescale 1ns/1ps

module dcache_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // cpu side
  input  logic                       req_valid_i,
  input  dcache_bus_pkg::cpu_req_t   req_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output dcache_bus_pkg::cpu_rsp_t   rsp_o,
  // axi master
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,
  output dcache_bus_pkg::axi_addr_t  aw_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,
  output dcache_bus_pkg::axi_wdata_t w_o,
  input  logic                       b_valid_i,
  output logic                       b_ready_o,
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output dcache_bus_pkg::axi_addr_t  ar_o,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  input  dcache_bus_pkg::axi_wdata_t r_i
);
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  logic       s1_valid, s1_ready, s1_adv, hazard;
  cpu_req_t   s1_req;
  idx_t       s1_idx, ridx;
  logic       s2_valid, s2_ready, s2_done, s2_wr, s2_hit;
  cpu_req_t   s2_req;
  idx_t       s2_idx, data_raddr;
  way_t       s2_way;
  tag_entry_t s2_vict;
  logic       hit;
  way_t       hit_way, victim_way;
  tag_entry_t victim_entry, new_entry;
  line_t      data_rdata [WAY_NUM];
  line_t      line_sel, merged, wr_line, fill_line;
  word_t      load_data;
  logic       fsm_start, fsm_idle, fsm_done;

  // ========================================================================
  // ready chain
  // ========================================================================
  assign s1_idx = s1_req.addr[OFS_W +: IDX_W];
  assign s2_idx = s2_req.addr[OFS_W +: IDX_W];

  assign s2_done  = s2_valid & (s2_hit | fsm_done);
  assign s2_ready = ~s2_valid | s2_done;
  // store hit or refill completion writes the arrays
  assign s2_wr    = s2_done & (~s2_hit | (s2_req.op == OP_STORE));
  // same set in stage 1 must re-read after the write
  assign hazard   = s1_valid & s2_wr & (s1_idx == s2_idx);
  assign s1_adv   = s1_valid & s2_ready & ~hazard;
  assign s1_ready = ~s1_valid | (s2_ready & ~hazard);

  assign req_ready_o = s1_ready;
  assign ridx        = s1_ready ? req_i.addr[OFS_W +: IDX_W] : s1_idx;
  // data read follows whoever sits in stage 2 next
  assign data_raddr  = s2_ready ? s1_idx : s2_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      s2_valid    <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= req_valid_i;
      end
      if (s2_ready) begin
        s2_valid <= s1_adv;
      end
      rsp_valid_o <= s2_done;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_req <= req_i;
    end
    if (s2_ready) begin
      s2_req  <= s1_req;
      s2_hit  <= hit;
      s2_way  <= hit ? hit_way : victim_way;
      s2_vict <= victim_entry;
    end
    if (s2_done) begin
      rsp_o.op    <= s2_req.op;
      rsp_o.rdata <= load_data;
    end
  end

  // ========================================================================
  // arrays and datapath
  // ========================================================================
  assign new_entry.valid = 1'b1;
  assign new_entry.dirty = (s2_req.op == OP_STORE);
  assign new_entry.tag   = s2_req.addr[ADDR_W-1 -: TAG_W];

  dcache_lookup u_lookup (
    .clk            (clk),
    .rst_n          (rst_n),
    .ridx_i         (ridx),
    .s1_valid_i     (s1_adv),
    .s1_addr_i      (s1_req.addr),
    .tag_we_i       (s2_wr),
    .tag_way_i      (s2_way),
    .tag_idx_i      (s2_idx),
    .tag_entry_i    (new_entry),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_entry_o (victim_entry)
  );

  for (genvar w = 0; w < WAY_NUM; w++) begin : g_data_ram
    dcache_ram #(
      .DEPTH (SET_NUM),
      .WIDTH ($bits(line_t))
    ) u_data_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (s2_wr && (s2_way == way_t'(w))),
      .waddr_i (s2_idx),
      .wdata_i (wr_line),
      .raddr_i (data_raddr),
      .rdata_o (data_rdata[w])
    );
  end

  // refilled line replaces the stale array output on completion
  assign line_sel = fsm_done ? fill_line : data_rdata[s2_way];
  assign wr_line  = (s2_req.op == OP_STORE) ? merged : line_sel;

  dcache_align_unit u_align (
    .line_i        (line_sel),
    .addr_i        (s2_req.addr),
    .size_i        (s2_req.size),
    .is_unsigned_i (s2_req.is_unsigned),
    .wdata_i       (s2_req.wdata),
    .rdata_o       (load_data),
    .merged_o      (merged)
  );

  // one start pulse per miss
  assign fsm_start = s2_valid & ~s2_hit & fsm_idle & ~fsm_done;

  dcache_miss_fsm u_miss_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (fsm_start),
    .dirty_i       (s2_vict.valid & s2_vict.dirty),
    .victim_addr_i ({s2_vict.tag, s2_idx, {OFS_W{1'b0}}}),
    .fill_addr_i   ({s2_req.addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}}),
    .victim_line_i (data_rdata[s2_way]),
    .idle_o        (fsm_idle),
    .done_o        (fsm_done),
    .fill_line_o   (fill_line),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .aw_o          (aw_o),
    .w_valid_o     (w_valid_o),
    .w_ready_i     (w_ready_i),
    .w_o           (w_o),
    .b_valid_i     (b_valid_i),
    .b_ready_o     (b_ready_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .ar_o          (ar_o),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .r_i           (r_i)
  );

endmodule

// ==== bench/dcache_props.sv ====
// ==========================================================================
// AXI master assertions, bound into the cache top level
// ==========================================================================
`timescale 1ns/1ps

module dcache_props (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       aw_valid_i,
  input logic                       aw_ready_i,
  input dcache_bus_pkg::axi_addr_t  aw_i,
  input logic                       w_valid_i,
  input logic                       w_ready_i,
  input dcache_bus_pkg::axi_wdata_t w_i,
  input logic                       b_ready_i,
  input logic                       ar_valid_i,
  input logic                       ar_ready_i,
  input dcache_bus_pkg::axi_addr_t  ar_i
);

  logic       awar_bad = 1'b0;
  logic       aw_bad = 1'b0;
  logic       w_bad = 1'b0;
  logic       ar_bad = 1'b0;
  logic       last_bad = 1'b0;
  logic       len_bad = 1'b0;
  logic       bready_bad = 1'b0;
  int         fail_cnt;
  logic [1:0] w_beat_q;

  assign fail_cnt = int'(awar_bad) + int'(aw_bad) + int'(w_bad) + int'(ar_bad)
                  + int'(last_bad) + int'(len_bad) + int'(bready_bad);

  // accepted write beats within the current burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_beat_q <= '0;
    end else if (w_valid_i && w_ready_i) begin
      w_beat_q <= w_beat_q + 2'd1;
    end
  end

  a_no_aw_ar: assert property (@(posedge clk) disable iff (!rst_n)
    !(aw_valid_i && ar_valid_i))
    else begin
      awar_bad = 1'b1;
      $error("AW and AR valid in the same cycle");
    end

  a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
    else begin
      aw_bad = 1'b1;
      $error("AW valid or payload changed before ready");
    end

  a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
    else begin
      w_bad = 1'b1;
      $error("W valid or payload changed before ready");
    end

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else begin
      ar_bad = 1'b1;
      $error("AR valid or payload changed before ready");
    end

  a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid_i |-> (w_i.last == (w_beat_q == 2'd3)))
    else begin
      last_bad = 1'b1;
      $error("W last does not match the fourth beat");
    end

  // every burst moves one whole line in four beats
  a_len: assert property (@(posedge clk) disable iff (!rst_n)
    (!aw_valid_i || aw_i.len == 8'd3) && (!ar_valid_i || ar_i.len == 8'd3))
    else begin
      len_bad = 1'b1;
      $error("AW or AR burst length is not four beats");
    end

  a_b_ready: assert property (@(posedge clk) disable iff (!rst_n)
    b_ready_i)
    else begin
      bready_bad = 1'b1;
      $error("B ready dropped low");
    end

endmodule

bind dcache_top dcache_props props (
  .clk        (clk),
  .rst_n      (rst_n),
  .aw_valid_i (aw_valid_o),
  .aw_ready_i (aw_ready_i),
  .aw_i       (aw_o),
  .w_valid_i  (w_valid_o),
  .w_ready_i  (w_ready_i),
  .w_i        (w_o),
  .b_ready_i  (b_ready_o),
  .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .ar_i       (ar_o)
);

// ==== bench/dcache_checker.sv ====
// ==========================================================================
// response checker: pending request queue and byte-level reference memory
// ==========================================================================
`timescale 1ns/1ps

module dcache_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid_i,
  input  logic                     req_ready_i,
  input  dcache_bus_pkg::cpu_req_t req_i,
  input  logic                     rsp_valid_i,
  input  dcache_bus_pkg::cpu_rsp_t rsp_i,
  output int                       errors_o,
  output int                       pending_o
);
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  cpu_req_t   pend_q [$];
  logic [7:0] ref_mem [4096];
  int         errors = 0;

  assign errors_o = errors;

  // same initial contents as the AXI memory
  function automatic logic [7:0] init_byte(logic [11:0] a);
    return (a[7:0] + 8'h5a) ^ {a[11:8], a[11:8]};
  endfunction

  initial begin
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = init_byte(12'(i));
    end
  end

  // little endian, sign or zero extended
  function automatic word_t expect_load(cpu_req_t q);
    logic [11:0] a;
    logic [7:0]  b;
    logic [15:0] h;
    a = q.addr[11:0];
    b = ref_mem[a];
    h = {ref_mem[a + 12'd1], ref_mem[a]};
    case (q.size)
      SZ_B:    return q.is_unsigned ? {24'h0, b} : {{24{b[7]}}, b};
      SZ_H:    return q.is_unsigned ? {16'h0, h} : {{16{h[15]}}, h};
      default: return {ref_mem[a + 12'd3], ref_mem[a + 12'd2], h};
    endcase
  endfunction

  task automatic apply_store(cpu_req_t q);
    logic [11:0] a;
    a = q.addr[11:0];
    ref_mem[a] = q.wdata[7:0];
    if (q.size != SZ_B) begin
      ref_mem[a + 12'd1] = q.wdata[15:8];
    end
    if (q.size == SZ_W) begin
      ref_mem[a + 12'd2] = q.wdata[23:16];
      ref_mem[a + 12'd3] = q.wdata[31:24];
    end
  endtask

  // ========================================================================
  // in-order compare, stores take effect when they respond
  // ========================================================================
  always @(posedge clk or negedge rst_n) begin : compare
    cpu_req_t q;
    word_t    exp;
    if (!rst_n) begin
      pend_q.delete();
    end else begin
      if (rsp_valid_i) begin
        if (pend_q.size() == 0) begin
          errors++;
          $display("%0t: a response arrived while no request was pending", $time);
        end else begin
          q = pend_q.pop_front();
          if (rsp_i.op != q.op) begin
            errors++;
            $display("[ERROR] %0t: response op %0d for addr %h, expected op %0d",
                     $time, rsp_i.op, q.addr, q.op);
          end else if (q.op == OP_STORE) begin
            apply_store(q);
          end else begin
            exp = expect_load(q);
            if (rsp_i.rdata !== exp) begin
              errors++;
              $display("[ERROR] %0t: load addr %h size %0d unsigned %0d got %h, expected %h",
                       $time, q.addr, q.size, q.is_unsigned, rsp_i.rdata, exp);
            end
          end
        end
      end
      if (req_valid_i && req_ready_i) begin
        pend_q.push_back(req_i);
      end
    end
    pending_o = pend_q.size();
  end

endmodule

// ==== bench/tb_dcache.sv ====
// ==========================================================================
// data cache testbench: clock, reset, stimulus table, AXI memory, watchdog
// ==========================================================================
`timescale 1ns/1ps

module tb_dcache;
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  localparam int FIXED_N   = 28;
  localparam int RAND_N    = 12;
  localparam int STIM_N    = FIXED_N + RAND_N;
  localparam int MEM_BYTES = 4096;

  logic       clk = 1'b0;
  logic       rst_n = 1'b0;
  logic       req_valid = 1'b0;
  cpu_req_t   req = '0;
  logic       req_ready;
  logic       rsp_valid;
  cpu_rsp_t   rsp;
  logic       aw_valid;
  logic       aw_ready = 1'b0;
  axi_addr_t  aw;
  logic       w_valid;
  logic       w_ready = 1'b0;
  axi_wdata_t w;
  logic       b_valid = 1'b0;
  logic       b_ready;
  logic       ar_valid;
  logic       ar_ready = 1'b0;
  axi_addr_t  ar;
  logic       r_valid = 1'b0;
  logic       r_ready;
  axi_wdata_t r;

  integer      seed = 32'hccbdf0eb;
  cpu_req_t    stim [STIM_N];
  logic [7:0]  mem [MEM_BYTES];
  logic [11:0] wr_addr = '0;
  logic [11:0] rd_addr = '0;
  logic [2:0]  rd_left = '0;
  logic [31:0] axi_rnd;
  int          errors;
  int          pending;

  dcache_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .aw_valid_o  (aw_valid),
    .aw_ready_i  (aw_ready),
    .aw_o        (aw),
    .w_valid_o   (w_valid),
    .w_ready_i   (w_ready),
    .w_o         (w),
    .b_valid_i   (b_valid),
    .b_ready_o   (b_ready),
    .ar_valid_o  (ar_valid),
    .ar_ready_i  (ar_ready),
    .ar_o        (ar),
    .r_valid_i   (r_valid),
    .r_ready_o   (r_ready),
    .r_i         (r)
  );

  dcache_checker chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_ready_i (req_ready),
    .req_i       (req),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .errors_o    (errors),
    .pending_o   (pending)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // low address byte plus 5a, folded with the upper address bits
  function automatic logic [7:0] init_byte(logic [11:0] a);
    return (a[7:0] + 8'h5a) ^ {a[11:8], a[11:8]};
  endfunction

  function automatic cpu_req_t make_req(mem_op_t op, acc_size_t sz, logic uns,
                                        addr_t a, word_t d);
    cpu_req_t q;
    q.op          = op;
    q.size        = sz;
    q.is_unsigned = uns;
    q.addr        = a;
    q.wdata       = d;
    return q;
  endfunction

  // ========================================================================
  // stimulus table
  // ========================================================================
  task automatic build_table();
    logic [31:0] rv;
    addr_t       a;
    acc_size_t   sz;
    // cold misses, every size and sign mode
    stim[0]  = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h000, 32'h0);
    stim[1]  = make_req(OP_LOAD,  SZ_B, 1'b0, 32'h031, 32'h0);
    stim[2]  = make_req(OP_LOAD,  SZ_B, 1'b1, 32'h032, 32'h0);
    stim[3]  = make_req(OP_LOAD,  SZ_H, 1'b0, 32'h046, 32'h0);
    stim[4]  = make_req(OP_LOAD,  SZ_H, 1'b1, 32'h04a, 32'h0);
    stim[5]  = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h04c, 32'h0);
    // repeated loads hit
    stim[6]  = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h000, 32'h0);
    stim[7]  = make_req(OP_LOAD,  SZ_B, 1'b0, 32'h031, 32'h0);
    // store merge and neighbours
    stim[8]  = make_req(OP_STORE, SZ_B, 1'b0, 32'h101, 32'h000000a5);
    stim[9]  = make_req(OP_LOAD,  SZ_B, 1'b1, 32'h101, 32'h0);
    stim[10] = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h100, 32'h0);
    stim[11] = make_req(OP_STORE, SZ_H, 1'b0, 32'h106, 32'h00008123);
    stim[12] = make_req(OP_LOAD,  SZ_H, 1'b0, 32'h106, 32'h0);
    stim[13] = make_req(OP_LOAD,  SZ_B, 1'b0, 32'h107, 32'h0);
    stim[14] = make_req(OP_STORE, SZ_W, 1'b0, 32'h108, 32'hdeadbeef);
    stim[15] = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h108, 32'h0);
    stim[16] = make_req(OP_LOAD,  SZ_B, 1'b1, 32'h10a, 32'h0);
    // set 3 thrash, 256 bytes apart
    stim[17] = make_req(OP_STORE, SZ_W, 1'b0, 32'h230, 32'h11112222);
    stim[18] = make_req(OP_STORE, SZ_W, 1'b0, 32'h330, 32'h33334444);
    stim[19] = make_req(OP_STORE, SZ_W, 1'b0, 32'h430, 32'h55556666);
    stim[20] = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h230, 32'h0);
    stim[21] = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h330, 32'h0);
    stim[22] = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h430, 32'h0);
    stim[23] = make_req(OP_LOAD,  SZ_B, 1'b0, 32'h232, 32'h0);
    stim[24] = make_req(OP_STORE, SZ_H, 1'b0, 32'h532, 32'h0000cafe);
    stim[25] = make_req(OP_LOAD,  SZ_H, 1'b1, 32'h532, 32'h0);
    stim[26] = make_req(OP_LOAD,  SZ_W, 1'b0, 32'h230, 32'h0);
    stim[27] = make_req(OP_LOAD,  SZ_B, 1'b1, 32'h105, 32'h0);
    // random back-to-back tail, naturally aligned
    for (int i = FIXED_N; i < STIM_N; i++) begin
      rv = $random(seed);
      a  = {21'h0, rv[10:0]};
      sz = SZ_W;
      if (rv[13:12] == 2'd0) begin
        sz = SZ_B;
      end else if (rv[13:12] == 2'd1) begin
        sz = SZ_H;
        a[0] = 1'b0;
      end else begin
        a[1:0] = 2'b00;
      end
      stim[i] = make_req(rv[14] ? OP_STORE : OP_LOAD, sz, rv[15], a, $random(seed));
    end
  endtask

  // ========================================================================
  // AXI slave memory model
  // ========================================================================
  initial begin
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = init_byte(12'(i));
    end
  end

  assign r.data = {mem[rd_addr + 12'd3], mem[rd_addr + 12'd2],
                   mem[rd_addr + 12'd1], mem[rd_addr]};
  assign r.last = (rd_left == 3'd1);

  // handshakes taken at the edge, slave outputs move 1 ns later
  initial begin : axi_slave
    logic       rst_s;
    logic       aw_fire;
    logic       w_fire;
    logic       b_fire;
    logic       ar_fire;
    logic       r_fire;
    axi_addr_t  aw_s;
    axi_addr_t  ar_s;
    axi_wdata_t w_s;
    forever begin
      @(posedge clk);
      rst_s   = rst_n;
      aw_fire = aw_valid && aw_ready;
      w_fire  = w_valid && w_ready;
      b_fire  = b_valid && b_ready;
      ar_fire = ar_valid && ar_ready;
      r_fire  = r_valid && r_ready;
      aw_s    = aw;
      w_s     = w;
      ar_s    = ar;
      #1;
      if (!rst_s) begin
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        ar_ready = 1'b0;
        b_valid  = 1'b0;
        r_valid  = 1'b0;
        rd_left  = '0;
      end else begin
        axi_rnd  = $random(seed);
        aw_ready = axi_rnd[0];
        w_ready  = axi_rnd[1] | axi_rnd[2];
        ar_ready = axi_rnd[3];
        if (aw_fire) begin
          wr_addr = aw_s.addr[11:0];
        end
        if (w_fire) begin
          for (int b = 0; b < 4; b++) begin
            mem[wr_addr + 12'(b)] = w_s.data[8*b +: 8];
          end
          wr_addr = wr_addr + 12'd4;
          if (w_s.last) begin
            b_valid = 1'b1;
          end
        end
        if (b_fire) begin
          b_valid = 1'b0;
        end
        if (ar_fire) begin
          rd_addr = ar_s.addr[11:0];
          rd_left = 3'd4;
        end
        // a raised r_valid holds until the beat is taken
        if (r_fire) begin
          rd_addr = rd_addr + 12'd4;
          rd_left = rd_left - 3'd1;
          r_valid = (rd_left != 3'd0) && axi_rnd[4];
        end else if (!r_valid && rd_left != 3'd0) begin
          r_valid = axi_rnd[4];
        end
      end
    end
  end

  // ========================================================================
  // main sequence and watchdog
  // ========================================================================
  initial begin
    build_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < STIM_N; i++) begin
      req_valid = 1'b1;
      req       = stim[i];
      @(posedge clk);
      while (!req_ready) begin
        @(posedge clk);
      end
      #1;
    end
    req_valid = 1'b0;
    wait (pending == 0);
    repeat (4) @(posedge clk);
    $display("errors: %0d, failed assertions: %0d, pending requests: %0d",
             errors, dut.props.fail_cnt, pending);
    if (errors == 0 && dut.props.fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (STIM_N * 200) @(posedge clk);
    $display("timeout after %0d cycles with %0d requests still pending",
             STIM_N * 200, pending);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/dcache_cfg_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dcache_ram.sv
verilog/dcache_lookup.sv
verilog/dcache_align_unit.sv
verilog/dcache_miss_fsm.sv
verilog/dcache_top.sv
bench/dcache_props.sv
bench/dcache_checker.sv
bench/tb_dcache.sv

// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = tb_dcache
FLIST    = flist.f
OBJDIR   = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
